// File: logic/isa_pkg.sv
package isa_pkg;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LUI   = 6'b001111,
    OP_LB    = 6'b100000,
    OP_LH    = 6'b100001,
    OP_LW    = 6'b100011,
    OP_LBU   = 6'b100100,
    OP_LHU   = 6'b100101,
    OP_SB    = 6'b101000,
    OP_SH    = 6'b101001,
    OP_SW    = 6'b101011
  } op_e;  // branches and jumps fall to the idle default

  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000,
    FN_SRL  = 6'b000010,
    FN_SRA  = 6'b000011,
    FN_ADDU = 6'b100001,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_NOR  = 6'b100111,
    FN_SLT  = 6'b101010
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_IDLE
  } alu_op_e;

  typedef enum logic [1:0] {
    SEL_MEM    = 2'b00,  // address add for loads and stores
    SEL_BRANCH = 2'b01,  // resolved in decode, alu stays idle
    SEL_RTYPE  = 2'b10,  // op taken from funct
    SEL_IMM    = 2'b11   // op taken from opcode
  } alu_sel_e;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

  localparam int XLEN  = 32;  // data path width
  localparam int REG_W = 5;   // register index width

  typedef enum logic [1:0] {
    SZ_BYTE = 2'b00,
    SZ_HALF = 2'b01,
    SZ_WORD = 2'b11
  } size_e;

  typedef enum logic [1:0] {
    FWD_RF  = 2'b00,  // value read in decode
    FWD_WB  = 2'b01,  // mem/wb write-back value
    FWD_MEM = 2'b10   // ex/mem alu result
  } fwd_sel_e;

  typedef struct packed {
    logic               wb_write;      // writes the register file
    logic               mem_to_reg;    // 1 takes load data at write-back
    logic               mem_read;      // load
    logic               mem_write;     // store
    logic               mem_unsigned;  // zero-extend loaded byte/half
    size_e              mem_size;
    logic               alu_src;       // 1 puts the immediate on operand b
    logic               reg_dst;       // 1 writes rd, else rt
    isa_pkg::alu_sel_e  alu_sel;
  } ctrl_t;

  typedef struct packed {
    ctrl_t             ctrl;
    logic [XLEN-1:0]   ra;
    logic [XLEN-1:0]   rb;
    logic [XLEN-1:0]   imm;    // already extended
    logic [REG_W-1:0]  rs;
    logic [REG_W-1:0]  rt;
    logic [REG_W-1:0]  rd;
    logic [4:0]        shamt;
    logic [5:0]        funct;
    logic [5:0]        opcode;
  } idex_t;

  typedef struct packed {
    logic              wb_write;
    logic [REG_W-1:0]  write_reg;
    logic [XLEN-1:0]   wb_data;
  } memwb_t;

endpackage

// File: logic/ex_fwd_if.sv
interface ex_fwd_if;
  import pipe_pkg::*;

  logic [REG_W-1:0] write_reg;  // destination held by the later stage
  logic             wb_write;   // that stage will write it
  logic             is_load;    // value is an address, data not back yet
  logic [XLEN-1:0]  value;      // result available for forwarding

  modport src (
    output write_reg,
    output wb_write,
    output is_load,
    output value
  );

  modport snoop (
    input write_reg,
    input wb_write,
    input is_load,
    input value
  );

endinterface

// File: logic/id_control.sv
module id_control (
  input  logic                      i_clk,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic [31:0]               i_instr,
  input  logic [pipe_pkg::XLEN-1:0] i_ra,
  input  logic [pipe_pkg::XLEN-1:0] i_rb,
  ex_fwd_if.snoop                   i_ex_fwd,  // memory stage view
  output logic                      o_stall,
  output pipe_pkg::idex_t           o_idex,
  output logic                      o_bubble
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [5:0]       opcode;
  logic [REG_W-1:0] rs, rt;
  ctrl_t            ctrl;
  logic             sign_ext;  // sign vs zero extension of imm16
  logic             reads_rs, reads_rt;
  logic             ld_q;      // id/ex slot holds a load
  logic [REG_W-1:0] ld_rt_q;   // its destination
  logic             stall_q;
  logic             hazard, same_ld;

  assign opcode = i_instr[31:26];
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];

  always_comb begin
    ctrl         = '0;
    ctrl.alu_sel = SEL_BRANCH;  // idle, writes nothing
    sign_ext     = 1'b1;
    reads_rs     = 1'b0;
    reads_rt     = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        case (i_instr[5:0])
          FN_SLL, FN_SRL, FN_SRA: begin  // shifts use rt and shamt only
            ctrl.wb_write = 1'b1;
            reads_rt      = 1'b1;
          end
          FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT: begin
            ctrl.wb_write = 1'b1;
            reads_rs      = 1'b1;
            reads_rt      = 1'b1;
          end
          default: ;  // unknown funct stays idle
        endcase
        if (ctrl.wb_write) begin
          ctrl.alu_sel = SEL_RTYPE;
          ctrl.reg_dst = 1'b1;
        end
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.wb_write = 1'b1;
        ctrl.alu_src  = 1'b1;
        ctrl.alu_sel  = SEL_IMM;
        reads_rs      = (opcode != OP_LUI);
        sign_ext      = (opcode == OP_ADDIU) || (opcode == OP_SLTI);
      end
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
        ctrl.wb_write     = 1'b1;
        ctrl.mem_to_reg   = 1'b1;
        ctrl.mem_read     = 1'b1;
        ctrl.alu_src      = 1'b1;
        ctrl.alu_sel      = SEL_MEM;
        ctrl.mem_unsigned = (opcode == OP_LBU) || (opcode == OP_LHU);
        ctrl.mem_size     = (opcode == OP_LW) ? SZ_WORD :
                            (opcode == OP_LH || opcode == OP_LHU) ? SZ_HALF : SZ_BYTE;
        reads_rs          = 1'b1;
      end
      OP_SB, OP_SH, OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_sel   = SEL_MEM;
        ctrl.mem_size  = (opcode == OP_SW) ? SZ_WORD :
                         (opcode == OP_SH) ? SZ_HALF : SZ_BYTE;
        reads_rs       = 1'b1;
        reads_rt       = 1'b1;  // store data
      end
      default: ;
    endcase
  end

  // load-use against the load sitting in id/ex
  assign hazard   = ld_q && ((reads_rs && rs == ld_rt_q) || (reads_rt && rt == ld_rt_q));
  // that load already stalled us once and now sits in the memory stage
  assign same_ld  = stall_q && i_ex_fwd.is_load && (i_ex_fwd.write_reg == ld_rt_q);
  assign o_stall  = i_valid && hazard && !same_ld;
  assign o_bubble = o_stall || !i_valid;

  always_comb begin
    o_idex.ctrl   = ctrl;
    o_idex.ra     = i_ra;
    o_idex.rb     = i_rb;
    o_idex.imm    = {{16{sign_ext & i_instr[15]}}, i_instr[15:0]};
    o_idex.rs     = rs;
    o_idex.rt     = rt;
    o_idex.rd     = i_instr[15:11];
    o_idex.shamt  = i_instr[10:6];
    o_idex.funct  = i_instr[5:0];
    o_idex.opcode = opcode;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ld_q    <= 1'b0;
      ld_rt_q <= '0;
      stall_q <= 1'b0;
    end else begin
      stall_q <= o_stall;
      ld_q    <= !o_bubble && ctrl.mem_read && (rt != '0);  // r0 loads never hazard
      if (!o_bubble) begin
        ld_rt_q <= rt;  // kept through a stall
      end
    end
  end

endmodule

// File: logic/forward_unit.sv
module forward_unit (
  input  logic [pipe_pkg::REG_W-1:0] i_rs,
  input  logic [pipe_pkg::REG_W-1:0] i_rt,
  ex_fwd_if.snoop                    mem_fwd,
  ex_fwd_if.snoop                    wb_fwd,
  output pipe_pkg::fwd_sel_e         o_sel_a,
  output pipe_pkg::fwd_sel_e         o_sel_b
);
  import pipe_pkg::*;

  // memory stage wins over write-back, r0 is never forwarded
  function automatic fwd_sel_e pick(
    input logic [REG_W-1:0] src,
    input logic [REG_W-1:0] mem_reg,
    input logic             mem_we,
    input logic [REG_W-1:0] wb_reg,
    input logic             wb_we
  );
    fwd_sel_e sel;
    sel = FWD_RF;
    if (src != '0) begin
      if (mem_we && mem_reg == src) begin
        sel = FWD_MEM;
      end else if (wb_we && wb_reg == src) begin
        sel = FWD_WB;
      end
    end
    return sel;
  endfunction

  assign o_sel_a = pick(i_rs, mem_fwd.write_reg, mem_fwd.wb_write,
                        wb_fwd.write_reg, wb_fwd.wb_write);
  assign o_sel_b = pick(i_rt, mem_fwd.write_reg, mem_fwd.wb_write,
                        wb_fwd.write_reg, wb_fwd.wb_write);

endmodule

// File: logic/pipe_stage.sv
module pipe_stage #(
  parameter type T = logic  // payload struct
) (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_bubble,  // load an empty slot instead of i_d
  input  T     i_d,
  output T     o_q
);

  // an all-zero payload writes nothing and touches no memory
  always_ff @(posedge i_clk) begin
    if (i_reset || i_bubble) begin
      o_q <= '0;
    end else begin
      o_q <= i_d;
    end
  end

endmodule

// File: logic/alu.sv
module alu (
  input  isa_pkg::alu_op_e          i_op,
  input  logic [pipe_pkg::XLEN-1:0] i_a,
  input  logic [pipe_pkg::XLEN-1:0] i_b,
  input  logic [4:0]                i_shamt,
  output logic [pipe_pkg::XLEN-1:0] o_result
);
  import isa_pkg::*;

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_result = i_a + i_b;
      end
      ALU_SUB: begin
        o_result = i_a - i_b;
      end
      ALU_AND: begin
        o_result = i_a & i_b;
      end
      ALU_OR: begin
        o_result = i_a | i_b;
      end
      ALU_XOR: begin
        o_result = i_a ^ i_b;
      end
      ALU_NOR: begin
        o_result = ~(i_a | i_b);
      end
      ALU_SLT: begin
        o_result = ($signed(i_a) < $signed(i_b)) ? 1 : 0;  // signed compare
      end
      ALU_SLL: begin
        o_result = i_b << i_shamt;  // shifts act on rt
      end
      ALU_SRL: begin
        o_result = i_b >> i_shamt;
      end
      ALU_SRA: begin
        o_result = $signed(i_b) >>> i_shamt;  // keeps the sign bit
      end
      ALU_LUI: begin
        o_result = {i_b[15:0], 16'b0};
      end
      default: begin
        o_result = '0;  // idle
      end
    endcase
  end

endmodule

// File: logic/instruction_execute.sv
module instruction_execute (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  pipe_pkg::idex_t            i_idex,
  input  pipe_pkg::fwd_sel_e         i_sel_a,
  input  pipe_pkg::fwd_sel_e         i_sel_b,
  input  logic [pipe_pkg::XLEN-1:0]  i_mem_value,  // ex/mem alu result
  input  logic [pipe_pkg::XLEN-1:0]  i_wb_value,   // mem/wb write-back data
  output pipe_pkg::ctrl_t            o_ctrl,
  output logic [pipe_pkg::REG_W-1:0] o_write_reg,
  output logic [pipe_pkg::XLEN-1:0]  o_store_data,
  output logic [pipe_pkg::XLEN-1:0]  o_alu_result
);
  import isa_pkg::*;
  import pipe_pkg::*;

  alu_op_e         alu_op;
  logic [XLEN-1:0] op_a, rt_fwd, op_b;
  logic [XLEN-1:0] alu_res;

  function automatic logic [XLEN-1:0] fwd_mux(
    input fwd_sel_e        sel,
    input logic [XLEN-1:0] rf,
    input logic [XLEN-1:0] wb,
    input logic [XLEN-1:0] mem
  );
    case (sel)
      FWD_RF:  return rf;
      FWD_WB:  return wb;
      FWD_MEM: return mem;
      default: return '0;
    endcase
  endfunction

  always_comb begin
    case (i_idex.ctrl.alu_sel)
      SEL_MEM: begin
        alu_op = ALU_ADD;  // base plus offset
      end
      SEL_RTYPE: begin
        case (i_idex.funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          default: alu_op = ALU_IDLE;
        endcase
      end
      SEL_IMM: begin
        case (i_idex.opcode)
          OP_ADDIU: alu_op = ALU_ADD;
          OP_SLTI:  alu_op = ALU_SLT;
          OP_ANDI:  alu_op = ALU_AND;
          OP_ORI:   alu_op = ALU_OR;
          OP_XORI:  alu_op = ALU_XOR;
          OP_LUI:   alu_op = ALU_LUI;
          default:  alu_op = ALU_IDLE;
        endcase
      end
      default: begin
        alu_op = ALU_IDLE;  // branch class
      end
    endcase
  end

  assign op_a   = fwd_mux(i_sel_a, i_idex.ra, i_wb_value, i_mem_value);
  assign rt_fwd = fwd_mux(i_sel_b, i_idex.rb, i_wb_value, i_mem_value);
  assign op_b   = i_idex.ctrl.alu_src ? i_idex.imm : rt_fwd;

  alu u_alu (
    .i_op     (alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .i_shamt  (i_idex.shamt),
    .o_result (alu_res)
  );

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ctrl       <= '0;
      o_write_reg  <= '0;
      o_store_data <= '0;
      o_alu_result <= '0;
    end else begin
      o_ctrl       <= i_idex.ctrl;
      o_write_reg  <= i_idex.ctrl.reg_dst ? i_idex.rd : i_idex.rt;
      o_store_data <= rt_fwd;  // before the immediate mux
      o_alu_result <= alu_res;
    end
  end

endmodule

// File: logic/ex_subsystem.sv
module ex_subsystem (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_valid,
  input  logic [31:0]                i_instr,
  input  logic [pipe_pkg::XLEN-1:0]  i_ra,
  input  logic [pipe_pkg::XLEN-1:0]  i_rb,
  input  logic [pipe_pkg::XLEN-1:0]  i_mem_rdata,  // valid while o_mem_read
  output logic                       o_stall,
  output logic                       o_wb_write_ex,
  output logic                       o_mem_read,
  output logic                       o_mem_write,
  output logic                       o_mem_unsigned,
  output pipe_pkg::size_e            o_mem_size,
  output logic [pipe_pkg::REG_W-1:0] o_write_reg,
  output logic [pipe_pkg::XLEN-1:0]  o_alu_result,
  output logic [pipe_pkg::XLEN-1:0]  o_store_data,
  output logic                       o_wb_en,
  output logic [pipe_pkg::REG_W-1:0] o_wb_reg,
  output logic [pipe_pkg::XLEN-1:0]  o_wb_data
);
  import pipe_pkg::*;

  idex_t    idex_d, idex_q;
  memwb_t   memwb_d, memwb_q;
  ctrl_t    ex_ctrl;
  fwd_sel_e sel_a, sel_b;
  logic     id_bubble;

  ex_fwd_if mem_fwd ();
  ex_fwd_if wb_fwd ();

  id_control u_id_control (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_valid  (i_valid),
    .i_instr  (i_instr),
    .i_ra     (i_ra),
    .i_rb     (i_rb),
    .i_ex_fwd (mem_fwd),
    .o_stall  (o_stall),
    .o_idex   (idex_d),
    .o_bubble (id_bubble)
  );

  pipe_stage #(.T(idex_t)) u_idex (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_bubble (id_bubble),
    .i_d      (idex_d),
    .o_q      (idex_q)
  );

  forward_unit u_forward (
    .i_rs    (idex_q.rs),
    .i_rt    (idex_q.rt),
    .mem_fwd (mem_fwd),
    .wb_fwd  (wb_fwd),
    .o_sel_a (sel_a),
    .o_sel_b (sel_b)
  );

  instruction_execute u_execute (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_idex       (idex_q),
    .i_sel_a      (sel_a),
    .i_sel_b      (sel_b),
    .i_mem_value  (mem_fwd.value),
    .i_wb_value   (wb_fwd.value),
    .o_ctrl       (ex_ctrl),
    .o_write_reg  (o_write_reg),
    .o_store_data (o_store_data),
    .o_alu_result (o_alu_result)
  );

  // write-back picks load data or the alu result
  assign memwb_d = '{wb_write:  ex_ctrl.wb_write,
                     write_reg: o_write_reg,
                     wb_data:   ex_ctrl.mem_to_reg ? i_mem_rdata : o_alu_result};

  pipe_stage #(.T(memwb_t)) u_memwb (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_bubble (!ex_ctrl.wb_write),  // stores and idles leave an empty slot
    .i_d      (memwb_d),
    .o_q      (memwb_q)
  );

  assign mem_fwd.write_reg = o_write_reg;
  assign mem_fwd.wb_write  = ex_ctrl.wb_write;
  assign mem_fwd.is_load   = ex_ctrl.mem_read;
  assign mem_fwd.value     = o_alu_result;

  assign wb_fwd.write_reg  = memwb_q.write_reg;
  assign wb_fwd.wb_write   = memwb_q.wb_write;
  assign wb_fwd.is_load    = 1'b0;  // data already resolved here
  assign wb_fwd.value      = memwb_q.wb_data;

  assign o_wb_write_ex  = ex_ctrl.wb_write;
  assign o_mem_read     = ex_ctrl.mem_read;
  assign o_mem_write    = ex_ctrl.mem_write;
  assign o_mem_unsigned = ex_ctrl.mem_unsigned;
  assign o_mem_size     = ex_ctrl.mem_size;
  assign o_wb_en        = memwb_q.wb_write;
  assign o_wb_reg       = memwb_q.write_reg;
  assign o_wb_data      = memwb_q.wb_data;

endmodule

// File: verif/ex_subsystem_asserts.sv
module ex_subsystem_asserts (
  input logic i_clk,
  input logic i_reset,
  input logic i_stall,   // load-use stall level
  input logic i_bubble,  // slot loads an empty payload
  input logic i_empty    // slot payload is all zero
);

  int fails = 0;  // failed assertions so far

  // a load-use stall is a single cycle, the held load moves on
  stall_one_cycle: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_stall |=> !i_stall
  ) else begin
    $error("stall held for a second cycle");
    fails++;
  end

  // bubbled slot writes nothing and touches no memory
  bubble_is_empty: assert property (
    @(posedge i_clk) disable iff (i_reset)
    i_bubble |=> i_empty
  ) else begin
    $error("bubbled slot carries a live payload");
    fails++;
  end

  reset_is_quiet: assert property (
    @(posedge i_clk)
    i_reset |=> (i_empty && !i_stall)  // controls low right after reset
  ) else begin
    $error("controls active in the cycle after reset");
    fails++;
  end

endmodule

bind id_control ex_subsystem_asserts u_stall_asserts (
  .i_clk    (i_clk),
  .i_reset  (i_reset),
  .i_stall  (o_stall),
  .i_bubble (1'b0),
  .i_empty  (1'b1)
);

bind pipe_stage ex_subsystem_asserts u_slot_asserts (
  .i_clk    (i_clk),
  .i_reset  (i_reset),
  .i_stall  (1'b0),
  .i_bubble (i_bubble),
  .i_empty  (o_q == '0)
);

// File: verif/ex_subsystem_tb.sv
module ex_subsystem_tb;
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int PERIOD    = 100;
  localparam int NUM_TESTS = 5;
  localparam int TEST_CYC  = 400;  // longest test, alu sweep is about 390
  localparam int ROUNDS    = 6;    // 4 edge pairs then random

  typedef struct packed {
    logic [XLEN-1:0]  alu;
    logic [XLEN-1:0]  sd;   // store data
    logic [XLEN-1:0]  wbd;  // write-back data, load data for loads
    logic [REG_W-1:0] wr;
    logic             wbw;
    logic             mr;
    logic             mw;
    logic             uns;
    size_e            sz;
  } exp_t;

  logic clk, reset, valid;
  logic [31:0] instr;
  logic [XLEN-1:0] ra, rb, mem_rdata;
  logic stall, wb_write_ex, mem_read, mem_write, mem_unsigned, wb_en;
  size_e mem_size;
  logic [REG_W-1:0] write_reg, wb_reg;
  logic [XLEN-1:0] alu_result, store_data, wb_data;

  logic [XLEN-1:0] rf [32];    // outside register file, written at write-back
  logic [XLEN-1:0] arch [32];  // program-order state of the reference model
  exp_t slot_idex, slot_mem, slot_wb;
  integer seed;
  int errors, checks, stall_cycles;

  ex_subsystem UUT (
    .i_clk (clk), .i_reset (reset), .i_valid (valid), .i_instr (instr),
    .i_ra (ra), .i_rb (rb), .i_mem_rdata (mem_rdata), .o_stall (stall),
    .o_wb_write_ex (wb_write_ex), .o_mem_read (mem_read), .o_mem_write (mem_write),
    .o_mem_unsigned (mem_unsigned), .o_mem_size (mem_size), .o_write_reg (write_reg),
    .o_alu_result (alu_result), .o_store_data (store_data), .o_wb_en (wb_en),
    .o_wb_reg (wb_reg), .o_wb_data (wb_data)
  );

  always #(PERIOD / 2) clk = ~clk;

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_reg(input string name, input logic [REG_W-1:0] got,
                           input logic [REG_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_size(input string name, input size_e got, input size_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {OP_RTYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic size_e size_of(input logic [5:0] op);
    if (op == OP_LW || op == OP_SW) begin
      return SZ_WORD;
    end else if (op == OP_LH || op == OP_LHU || op == OP_SH) begin
      return SZ_HALF;
    end
    return SZ_BYTE;
  endfunction

  // source registers the instruction really reads, shifts and lui skip rs
  function automatic logic reads_reg(input logic [31:0] ins, input logic [REG_W-1:0] r);
    logic [5:0] op;
    logic       shift, use_rs, use_rt;
    op     = ins[31:26];
    shift  = (ins[5:0] == FN_SLL) || (ins[5:0] == FN_SRL) || (ins[5:0] == FN_SRA);
    use_rs = (op == OP_RTYPE) ? !shift : (op != OP_LUI);
    use_rt = (op == OP_RTYPE) || (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    return (use_rs && ins[25:21] == r) || (use_rt && ins[20:16] == r);
  endfunction

  // expected ex/mem and write-back values, advances arch in program order
  function automatic exp_t model(input logic [31:0] ins, input logic [XLEN-1:0] ld);
    exp_t            e;
    logic [5:0]      op;
    logic [XLEN-1:0] a, b, sx, zx;
    e     = '0;
    op    = ins[31:26];
    a     = arch[ins[25:21]];
    b     = arch[ins[20:16]];
    sx    = {{16{ins[15]}}, ins[15:0]};
    zx    = {16'h0, ins[15:0]};
    e.wr  = ins[20:16];  // rt unless r-type
    e.wbw = 1'b1;
    e.sd  = b;
    case (op)
      OP_RTYPE: begin
        e.wr = ins[15:11];
        case (ins[5:0])
          FN_ADDU: e.alu = a + b;
          FN_SUBU: e.alu = a - b;
          FN_AND:  e.alu = a & b;
          FN_OR:   e.alu = a | b;
          FN_XOR:  e.alu = a ^ b;
          FN_NOR:  e.alu = ~(a | b);
          FN_SLT:  e.alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLL:  e.alu = b << ins[10:6];
          FN_SRL:  e.alu = b >> ins[10:6];
          FN_SRA:  e.alu = $signed(b) >>> ins[10:6];
          default: e.wbw = 1'b0;
        endcase
      end
      OP_ADDIU: e.alu = a + sx;
      OP_SLTI:  e.alu = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      OP_ANDI:  e.alu = a & zx;  // logical immediates zero-extend
      OP_ORI:   e.alu = a | zx;
      OP_XORI:  e.alu = a ^ zx;
      OP_LUI:   e.alu = {ins[15:0], 16'h0};
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
        e.alu = a + sx;  // address
        e.mr  = 1'b1;
        e.uns = (op == OP_LBU) || (op == OP_LHU);
        e.sz  = size_of(op);
      end
      OP_SB, OP_SH, OP_SW: begin
        e.alu = a + sx;
        e.mw  = 1'b1;
        e.wbw = 1'b0;
        e.sz  = size_of(op);
      end
      default: e.wbw = 1'b0;
    endcase
    e.wbd = e.mr ? ld : e.alu;
    if (e.wbw && e.wr != '0) begin
      arch[e.wr] = e.wbd;
    end
    return e;
  endfunction

  task automatic check_mem_stage(input exp_t e);
    check_word("o_alu_result", alu_result, e.alu);
    check_reg("o_write_reg", write_reg, e.wr);
    check_bit("o_wb_write_ex", wb_write_ex, e.wbw);
    check_bit("o_mem_read", mem_read, e.mr);
    check_bit("o_mem_write", mem_write, e.mw);
    check_bit("o_mem_unsigned", mem_unsigned, e.uns);
    check_size("o_mem_size", mem_size, e.sz);
    if (e.mw) begin
      check_word("o_store_data", store_data, e.sd);  // forwarded rt
    end
  endtask

  task automatic check_wb_stage(input exp_t e);
    check_bit("o_wb_en", wb_en, e.wbw);
    check_reg("o_wb_reg", wb_reg, e.wr);
    check_word("o_wb_data", wb_data, e.wbd);
  endtask

  // one cycle from falling edge to falling edge
  task automatic step(input logic vld, input logic [31:0] ins, input exp_t e,
                      output logic stl);
    logic exp_stl;
    check_mem_stage(slot_mem);
    check_wb_stage(slot_wb);
    if (slot_wb.wbw && slot_wb.wr != '0) begin
      rf[slot_wb.wr] = slot_wb.wbd;  // write-through register file
    end
    exp_stl   = vld && slot_idex.mr && slot_idex.wr != '0 && reads_reg(ins, slot_idex.wr);
    valid     = vld;
    instr     = ins;
    ra        = rf[ins[25:21]];  // stale while a producer is in flight
    rb        = rf[ins[20:16]];
    mem_rdata = slot_mem.mr ? slot_mem.wbd : $random(seed);
    #(PERIOD / 4);
    check_bit("o_stall", stall, exp_stl);
    if (stall) begin
      stall_cycles++;
    end
    stl = exp_stl;
    @(posedge clk);
    slot_wb   = slot_mem.wbw ? slot_mem : '0;
    slot_mem  = slot_idex;
    slot_idex = (vld && !exp_stl) ? e : '0;
    @(negedge clk);
  endtask

  task automatic issue(input logic [31:0] ins, input logic [XLEN-1:0] ld);
    exp_t e;
    logic stl;
    e = model(ins, ld);
    step(1'b1, ins, e, stl);
    if (stl) begin
      step(1'b1, ins, e, stl);  // outside holds the instruction
    end
  endtask

  task automatic idle(input int n);
    logic stl;
    repeat (n) begin
      step(1'b0, $random(seed), '0, stl);
    end
  endtask

  task automatic set_reg(input logic [REG_W-1:0] r, input logic [XLEN-1:0] v);
    rf[r]   = v;  // only with the pipe drained
    arch[r] = v;
  endtask

  function automatic logic [XLEN-1:0] edge_val(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'h7fff_ffff;
      2:       return 32'h8000_0000;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  task automatic test_reset();
    check_bit("o_stall", stall, 1'b0);
    check_mem_stage('0);
    check_word("o_store_data", store_data, '0);
    check_wb_stage('0);
  endtask

  task automatic test_alu_ops();
    logic [5:0]      fn [10];
    logic [5:0]      iop [6];
    logic [XLEN-1:0] rnd;
    fn  = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA};
    iop = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    for (int k = 0; k < 16; k++) begin
      for (int r = 0; r < ROUNDS; r++) begin
        set_reg(1, (r < 4) ? edge_val(r) : $random(seed));
        set_reg(2, (r < 4) ? edge_val(3 - r) : $random(seed));
        rnd = $random(seed);
        if (k < 10) begin
          issue(rtype(fn[k], 1, 2, 3, rnd[4:0]), '0);  // rd = r3
        end else begin
          issue(itype(iop[k - 10], 1, 4, rnd[15:0]), '0);  // rt = r4
        end
        idle(3);  // ex/mem at 2, write-back at 3
      end
    end
  endtask

  task automatic test_forwarding();
    set_reg(5, $random(seed));
    set_reg(6, $random(seed));
    issue(rtype(FN_ADDU, 5, 6, 7, 0), '0);
    issue(rtype(FN_XOR, 7, 6, 8, 0), '0);   // a from memory stage
    issue(rtype(FN_SUBU, 5, 7, 9, 0), '0);  // b from write-back
    issue(rtype(FN_AND, 6, 9, 10, 0), '0);  // b from memory stage
    issue(rtype(FN_OR, 9, 5, 11, 0), '0);   // a from write-back
    issue(rtype(FN_SLL, 0, 11, 16, 5'd7), '0);
    issue(itype(OP_ADDIU, 5, 12, 16'h8001), '0);
    issue(itype(OP_ADDIU, 6, 12, 16'h0123), '0);
    issue(rtype(FN_ADDU, 12, 12, 13, 0), '0);  // both distances, memory stage wins
    issue(itype(OP_ADDIU, 5, 0, 16'h1234), '0);  // r0 write
    issue(rtype(FN_ADDU, 0, 0, 14, 0), '0);      // never forwarded
    issue(itype(OP_ORI, 0, 15, 16'h0005), '0);
    idle(3);
  endtask

  task automatic test_load_use();
    set_reg(20, 32'h0000_1000);
    stall_cycles = 0;
    issue(itype(OP_LW, 20, 21, 16'h0008), $random(seed));
    issue(rtype(FN_ADDU, 21, 5, 22, 0), '0);  // rs hazard
    issue(itype(OP_LBU, 20, 23, 16'hfffc), $random(seed));
    issue(itype(OP_SW, 20, 23, 16'h000c), '0);  // rt hazard on store data
    issue(itype(OP_LH, 20, 24, 16'h0002), $random(seed));
    issue(itype(OP_ADDIU, 5, 1, 16'h0010), '0);
    issue(rtype(FN_XOR, 24, 24, 25, 0), '0);  // distance 2, no stall
    issue(itype(OP_LB, 20, 0, 16'h0000), $random(seed));
    issue(rtype(FN_ADDU, 0, 5, 26, 0), '0);  // r0 load never hazards
    idle(3);
    if (stall_cycles != 2) begin
      errors++;
      $display("load-use test saw %0d stall cycles where 2 were expected", stall_cycles);
    end
  endtask

  task automatic test_stores();
    set_reg(28, 32'h0000_2000);
    set_reg(29, $random(seed));
    issue(itype(OP_SB, 28, 29, 16'hffff), '0);  // negative offset
    issue(itype(OP_SH, 28, 29, 16'h7ffe), '0);
    issue(itype(OP_SW, 28, 29, 16'h0004), '0);
    issue(itype(OP_ADDIU, 29, 29, 16'h0001), '0);
    issue(itype(OP_SW, 28, 29, 16'h0008), '0);  // data from memory stage
    issue(itype(OP_ADDIU, 28, 28, 16'h0100), '0);
    issue(itype(OP_ORI, 29, 30, 16'h00f0), '0);
    issue(itype(OP_SH, 28, 29, 16'hfff0), '0);  // base from write-back
    issue(itype(OP_SB, 28, 30, 16'h0003), '0);
    idle(3);
  endtask

  initial begin
    #((NUM_TESTS * TEST_CYC + 50) * PERIOD);
    $display("timeout, the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed      = 32'h8380b67f;
    clk       = 1'b0;
    reset     = 1'b1;
    valid     = 1'b0;
    instr     = '0;
    ra        = '0;
    rb        = '0;
    mem_rdata = '0;
    errors    = 0;
    checks    = 0;
    slot_idex = '0;
    slot_mem  = '0;
    slot_wb   = '0;
    for (int r = 0; r < 32; r++) begin
      rf[r]   = (r == 0) ? '0 : $random(seed);
      arch[r] = rf[r];
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset();
    test_alu_ops();
    test_forwarding();
    test_load_use();
    test_stores();
    errors += UUT.u_id_control.u_stall_asserts.fails;  // bound checkers
    errors += UUT.u_idex.u_slot_asserts.fails;
    errors += UUT.u_memwb.u_slot_asserts.fails;
    $display("%0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/ex_fwd_if.sv
logic/id_control.sv
logic/forward_unit.sv
logic/pipe_stage.sv
logic/alu.sv
logic/instruction_execute.sv
logic/ex_subsystem.sv
verif/ex_subsystem_asserts.sv
verif/ex_subsystem_tb.sv
